// File: Makefile
# Verilator build and run for the APR status subsystem

VERILATOR ?= verilator
TOP       ?= aprSubsystemTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
rtl/aprPkg.sv
rtl/ioCommandIssuer.sv
rtl/cmdQueue.sv
rtl/aprRegisters.sv
rtl/aprSubsystem.sv
testbench/aprSubsystem_checker.sv
testbench/aprSubsystemTb.sv

// File: rtl/aprPkg.sv
`default_nettype none

package aprPkg;

  localparam int WORD_WIDTH  = 18;
  localparam int NUM_FLAGS   = 8;
  localparam int QUEUE_DEPTH = 4;
  localparam int OP_WIDTH    = 2;

  // Sized to hold the value QUEUE_DEPTH itself
  localparam int COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
  localparam int PTR_WIDTH   = $clog2(QUEUE_DEPTH);

  // I/O bus functions
  localparam logic [OP_WIDTH-1:0] OP_CONO  = 2'd0;
  localparam logic [OP_WIDTH-1:0] OP_DATAO = 2'd1;
  localparam logic [OP_WIDTH-1:0] OP_CONI  = 2'd2;
  localparam logic [OP_WIDTH-1:0] OP_DATAI = 2'd3;

  // Same bus word, decoded by CONO or by DATAO/DATAI
  typedef union packed {
    struct packed {
      logic [2:0]           spare;
      logic [2:0]           pia;
      logic                 disableInts;
      logic                 enableInts;
      logic                 clearFlags;
      logic                 setFlags;
      logic [NUM_FLAGS-1:0] flagSelect;
    } conoView;
    struct packed {
      logic [6:0] spare;
      logic       userComp;
      logic       writeComp;
      logic       readComp;
      logic       fetchComp;
      logic [2:0] prevBlock;
      logic [2:0] currentBlock;
      logic       loadBlocks;
    } dataoView;
  } aprWord_u;

endpackage

`default_nettype wire

// File: rtl/aprRegisters.sv
`timescale 1ns/10ps
`default_nettype none

module aprRegisters
  import aprPkg::*;
(
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 headValid,
  input  logic [OP_WIDTH-1:0]  headOp,
  input  aprWord_u             headData,
  output logic                 pop,
  output logic                 creditReturn,
  input  logic [NUM_FLAGS-1:0] eventIn,
  output logic                 respValid,
  output aprWord_u             respData,
  input  logic                 respReady,
  output logic                 aprInterrupt,
  output logic [2:0]           piLevel,
  output logic [2:0]           currentBlock,
  output logic [2:0]           prevBlock
);

  logic [NUM_FLAGS-1:0]  flags;
  logic [NUM_FLAGS-1:0]  intEnable;
  logic [NUM_FLAGS-1:0]  setMask;
  logic [NUM_FLAGS-1:0]  clearMask;
  logic [NUM_FLAGS-1:0]  enableMask;
  logic [NUM_FLAGS-1:0]  disableMask;
  logic [2:0]            pia;
  logic [3:0]            compareBits;
  logic                  doCono;
  logic                  doDatao;
  logic                  doRead;
  logic [WORD_WIDTH-1:0] statusWord;
  aprWord_u              blockWord;

  // Hold the queue while a response is still waiting
  assign pop = headValid & (~respValid | respReady);

  assign doCono = pop & (headOp == OP_CONO);
  assign doDatao = pop & (headOp == OP_DATAO);
  assign doRead = pop & ((headOp == OP_CONI) | (headOp == OP_DATAI));

  assign aprInterrupt = |(flags & intEnable);
  assign piLevel = aprInterrupt ? pia : 3'd0;

  // CONI layout: flags low, enables above, interrupt in bit 16
  assign statusWord = WORD_WIDTH'({aprInterrupt, intEnable, flags});

  always_comb begin
    blockWord = '0;
    blockWord.dataoView.currentBlock = currentBlock;
    blockWord.dataoView.prevBlock = prevBlock;
    {blockWord.dataoView.fetchComp,
     blockWord.dataoView.readComp,
     blockWord.dataoView.writeComp,
     blockWord.dataoView.userComp} = compareBits;
  end

  always_comb begin
    setMask = '0;
    clearMask = '0;
    enableMask = '0;
    disableMask = '0;
    if (doCono) begin
      if (headData.conoView.setFlags) begin
        setMask = headData.conoView.flagSelect;
      end
      if (headData.conoView.clearFlags) begin
        clearMask = headData.conoView.flagSelect;
      end
      if (headData.conoView.enableInts) begin
        enableMask = headData.conoView.flagSelect;
      end
      if (headData.conoView.disableInts) begin
        disableMask = headData.conoView.flagSelect;
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
      intEnable <= '0;
      pia <= '0;
      compareBits <= '0;
      currentBlock <= '0;
      prevBlock <= '0;
      respValid <= 1'b0;
      creditReturn <= 1'b0;
    end else begin
      // Event pulse beats a clear in the same cycle
      flags <= (flags & ~clearMask) | setMask | eventIn;
      intEnable <= (intEnable & ~disableMask) | enableMask;
      if (doCono) begin
        pia <= headData.conoView.pia;
      end
      if (doDatao) begin
        compareBits <= {headData.dataoView.fetchComp, headData.dataoView.readComp,
                        headData.dataoView.writeComp, headData.dataoView.userComp};
        if (headData.dataoView.loadBlocks) begin
          currentBlock <= headData.dataoView.currentBlock;
          prevBlock <= headData.dataoView.prevBlock;
        end
      end
      respValid <= doRead | (respValid & ~respReady);
      creditReturn <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (doRead) begin
      if (headOp == OP_CONI) begin
        respData <= statusWord;
      end else begin
        respData <= blockWord;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/aprSubsystem.sv
`timescale 1ns/10ps
`default_nettype none

module aprSubsystem
  import aprPkg::*;
(
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 cmdValid,
  input  logic [OP_WIDTH-1:0]  cmdOp,
  input  aprWord_u             cmdData,
  output logic                 cmdReady,
  output logic                 respValid,
  output aprWord_u             respData,
  input  logic                 respReady,
  input  logic [NUM_FLAGS-1:0] eventIn,
  output logic                 aprInterrupt,
  output logic [2:0]           piLevel,
  output logic [2:0]           currentBlock,
  output logic [2:0]           prevBlock
);

  logic                pushValid;
  logic [OP_WIDTH-1:0] pushOp;
  aprWord_u            pushData;
  logic                headValid;
  logic [OP_WIDTH-1:0] headOp;
  aprWord_u            headData;
  logic                pop;
  logic                creditReturn;

  ioCommandIssuer issuer (
    .clk(clk), .arstN(arstN),
    .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdData(cmdData), .cmdReady(cmdReady),
    .pushValid(pushValid), .pushOp(pushOp), .pushData(pushData),
    .creditReturn(creditReturn)
  );

  cmdQueue queue (
    .clk(clk), .arstN(arstN),
    .pushValid(pushValid), .pushOp(pushOp), .pushData(pushData),
    .pop(pop),
    .headValid(headValid), .headOp(headOp), .headData(headData)
  );

  // Pops return credits to the issuer
  aprRegisters registers (
    .clk(clk), .arstN(arstN),
    .headValid(headValid), .headOp(headOp), .headData(headData),
    .pop(pop), .creditReturn(creditReturn),
    .eventIn(eventIn),
    .respValid(respValid), .respData(respData), .respReady(respReady),
    .aprInterrupt(aprInterrupt), .piLevel(piLevel),
    .currentBlock(currentBlock), .prevBlock(prevBlock)
  );

endmodule

`default_nettype wire

// File: rtl/cmdQueue.sv
`timescale 1ns/10ps
`default_nettype none

module cmdQueue
  import aprPkg::*;
(
  input  logic                clk,
  input  logic                arstN,
  input  logic                pushValid,
  input  logic [OP_WIDTH-1:0] pushOp,
  input  aprWord_u            pushData,
  input  logic                pop,
  output logic                headValid,
  output logic [OP_WIDTH-1:0] headOp,
  output aprWord_u            headData
);

  logic [OP_WIDTH-1:0]    opMem [QUEUE_DEPTH];
  aprWord_u               dataMem [QUEUE_DEPTH];
  logic [PTR_WIDTH-1:0]   wrPtr;
  logic [PTR_WIDTH-1:0]   rdPtr;
  logic [PTR_WIDTH-1:0]   rdPtrNext;
  logic [COUNT_WIDTH-1:0] count;
  logic [COUNT_WIDTH-1:0] storedAfterPop;

  assign rdPtrNext = rdPtr + PTR_WIDTH'(pop);
  // Entries written this edge reach the head one cycle later
  assign storedAfterPop = count - COUNT_WIDTH'(pop);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      headValid <= 1'b0;
    end else begin
      if (pushValid) begin
        wrPtr <= wrPtr + 1'b1;
      end
      rdPtr <= rdPtrNext;
      count <= count + COUNT_WIDTH'(pushValid) - COUNT_WIDTH'(pop);
      headValid <= storedAfterPop != '0;
    end
  end

  always_ff @(posedge clk) begin
    if (pushValid) begin
      opMem[wrPtr] <= pushOp;
      dataMem[wrPtr] <= pushData;
    end
    headOp <= opMem[rdPtrNext];
    headData <= dataMem[rdPtrNext];
  end

endmodule

`default_nettype wire

// File: rtl/ioCommandIssuer.sv
`timescale 1ns/10ps
`default_nettype none

module ioCommandIssuer
  import aprPkg::*;
(
  input  logic                clk,
  input  logic                arstN,
  input  logic                cmdValid,
  input  logic [OP_WIDTH-1:0] cmdOp,
  input  aprWord_u            cmdData,
  output logic                cmdReady,
  output logic                pushValid,
  output logic [OP_WIDTH-1:0] pushOp,
  output aprWord_u            pushData,
  input  logic                creditReturn
);

  logic [COUNT_WIDTH-1:0] creditCount;
  logic                   accept;

  // One credit per free slot in the queue
  assign cmdReady = creditCount != '0;
  assign accept = cmdValid & cmdReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      creditCount <= COUNT_WIDTH'(QUEUE_DEPTH);
      pushValid <= 1'b0;
    end else begin
      pushValid <= accept;
      // Accept and return together leave the count as it is
      case ({accept, creditReturn})
        2'b10: creditCount <= creditCount - 1'b1;
        2'b01: creditCount <= creditCount + 1'b1;
        default: creditCount <= creditCount;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pushOp <= cmdOp;
      pushData <= cmdData;
    end
  end

endmodule

`default_nettype wire

// File: testbench/aprSubsystemTb.sv
`timescale 1ns/10ps
`default_nettype none

module aprSubsystemTb
  import aprPkg::*;
();

  localparam int TIMEOUT = 100;
  localparam int MEM_WORDS = 256;

  // Record kinds in the test data file
  localparam logic [3:0] KIND_END_TEST = 4'h0;
  localparam logic [3:0] KIND_WRITE = 4'h1;
  localparam logic [3:0] KIND_READ = 4'h2;
  localparam logic [3:0] KIND_EVENT = 4'h3;
  localparam logic [3:0] KIND_IRQ = 4'h4;
  localparam logic [3:0] KIND_BLOCKS = 4'h5;
  localparam logic [3:0] KIND_STALL = 4'h6;
  localparam logic [3:0] KIND_DRAIN = 4'h7;
  localparam logic [3:0] KIND_BURST = 4'h8;
  localparam logic [3:0] KIND_CREDITS_GONE = 4'h9;
  localparam logic [3:0] KIND_EOF = 4'hF;

  logic                 clk;
  logic                 arstN;
  logic                 cmdValid;
  logic [OP_WIDTH-1:0]  cmdOp;
  aprWord_u             cmdData;
  logic                 cmdReady;
  logic                 respValid;
  aprWord_u             respData;
  logic                 respReady;
  logic [NUM_FLAGS-1:0] eventIn;
  logic                 aprInterrupt;
  logic [2:0]           piLevel;
  logic [2:0]           currentBlock;
  logic [2:0]           prevBlock;

  logic [19:0] vecMem [MEM_WORDS];
  aprWord_u    expectQ [$];
  int          errorCount;
  int          checkCount;
  int          testErrors;
  int          testCount;

  aprSubsystem dut (
    .clk(clk), .arstN(arstN),
    .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdData(cmdData), .cmdReady(cmdReady),
    .respValid(respValid), .respData(respData), .respReady(respReady),
    .eventIn(eventIn), .aprInterrupt(aprInterrupt), .piLevel(piLevel),
    .currentBlock(currentBlock), .prevBlock(prevBlock)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic reportFail(string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errorCount++;
    testErrors++;
  endtask

  task automatic abortRun(string why);
    $display("Run stopped at %0t: %s", $time, why);
    $display("Test failed");
    $finish;
  endtask

  task automatic checkWord(aprWord_u got, aprWord_u exp, string what);
    checkCount++;
    if (got !== exp) begin
      reportFail($sformatf("%s: got %05h, expected %05h", what, got, exp));
    end
  endtask

  task automatic checkIrq(logic irq, logic [2:0] level, logic [3:0] exp);
    checkCount++;
    if ({irq, level} !== exp) begin
      reportFail($sformatf("aprInterrupt/piLevel %0b/%0d, expected %0b/%0d",
                           irq, level, exp[3], exp[2:0]));
    end
  endtask

  task automatic checkBlocks(logic [2:0] cur, logic [2:0] prev, logic [7:0] exp);
    checkCount++;
    if (cur !== exp[6:4] || prev !== exp[2:0]) begin
      reportFail($sformatf("blocks %0d/%0d, expected %0d/%0d", cur, prev, exp[6:4], exp[2:0]));
    end
  endtask

  task automatic sendCommand(logic [OP_WIDTH-1:0] op, aprWord_u data);
    int waited;
    waited = 0;
    @(posedge clk);
    cmdValid <= 1'b1;
    cmdOp <= op;
    cmdData <= data;
    @(negedge clk);
    while (!cmdReady && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!cmdReady) begin
      abortRun("cmdReady stayed low, command could not be issued");
    end else begin
      // Accepted on this edge
      @(posedge clk);
      cmdValid <= 1'b0;
    end
  endtask

  task automatic takeResponse(aprWord_u exp, string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!respValid && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!respValid) begin
      abortRun("no response from the DUT");
    end else begin
      checkWord(respData, exp, what);
      @(posedge clk);
    end
  endtask

  task automatic pulseEvents(logic [NUM_FLAGS-1:0] pattern);
    @(posedge clk);
    eventIn <= pattern;
    @(posedge clk);
    eventIn <= '0;
  endtask

  task automatic waitCreditsGone();
    int waited;
    waited = 0;
    checkCount++;
    @(negedge clk);
    while (cmdReady && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (cmdReady) begin
      reportFail("cmdReady stayed high although responses were stalled");
    end
  endtask

  task automatic drainResponses();
    aprWord_u exp;
    int       stall;
    while (expectQ.size() > 0) begin
      exp = expectQ.pop_front();
      stall = $urandom_range(3, 0);
      @(posedge clk);
      repeat (stall) @(posedge clk);
      respReady <= 1'b1;
      takeResponse(exp, "burst response");
      respReady <= 1'b0;
    end
    respReady <= 1'b1;
  endtask

  initial begin
    int                  idx;
    logic                done;
    logic [3:0]          kind;
    logic [OP_WIDTH-1:0] op;
    aprWord_u            word;
    logic [19:0]         expWord;
    void'($urandom(2527));
    arstN = 1'b0;
    cmdValid = 1'b0;
    cmdOp = '0;
    cmdData = '0;
    respReady = 1'b1;
    eventIn = '0;
    errorCount = 0;
    checkCount = 0;
    testErrors = 0;
    testCount = 0;
    $readmemh("testbench/aprTestdata.txt", vecMem);
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
    idx = 0;
    done = 1'b0;
    while (!done && idx < MEM_WORDS - 3) begin
      kind = vecMem[idx][3:0];
      op = vecMem[idx + 1][OP_WIDTH-1:0];
      word = vecMem[idx + 2][WORD_WIDTH-1:0];
      expWord = vecMem[idx + 3];
      case (kind)
        KIND_END_TEST: begin
          $display("test %0d finished with %0d errors", word, testErrors);
          testCount++;
          testErrors = 0;
        end
        KIND_WRITE: sendCommand(op, word);
        KIND_READ: begin
          sendCommand(op, word);
          takeResponse(expWord[WORD_WIDTH-1:0], "read response");
        end
        KIND_EVENT: pulseEvents(word[NUM_FLAGS-1:0]);
        KIND_IRQ: begin
          @(negedge clk);
          checkIrq(aprInterrupt, piLevel, expWord[3:0]);
        end
        KIND_BLOCKS: begin
          @(negedge clk);
          checkBlocks(currentBlock, prevBlock, expWord[7:0]);
        end
        KIND_STALL: begin
          @(posedge clk);
          respReady <= 1'b0;
        end
        KIND_BURST: begin
          sendCommand(op, word);
          if (op == OP_CONI || op == OP_DATAI) begin
            expectQ.push_back(expWord[WORD_WIDTH-1:0]);
          end
        end
        KIND_CREDITS_GONE: waitCreditsGone();
        KIND_DRAIN: drainResponses();
        KIND_EOF: done = 1'b1;
        default: begin
          reportFail("unknown record kind in the test data file");
          done = 1'b1;
        end
      endcase
      idx += 4;
    end
    // Protocol assertion failures count as errors too
    errorCount += dut.protocolCheck.failCount;
    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

bind aprSubsystem aprSubsystemChecker protocolCheck (
  .clk(clk), .arstN(arstN),
  .cmdValid(cmdValid), .cmdReady(cmdReady),
  .pushValid(pushValid), .creditReturn(creditReturn),
  .headValid(headValid), .pop(pop),
  .respValid(respValid), .respData(respData), .respReady(respReady)
);

`default_nettype wire

// File: testbench/aprSubsystem_checker.sv
`timescale 1ns/10ps
`default_nettype none

module aprSubsystemChecker
  import aprPkg::*;
(
  input logic     clk,
  input logic     arstN,
  input logic     cmdValid,
  input logic     cmdReady,
  input logic     pushValid,
  input logic     creditReturn,
  input logic     headValid,
  input logic     pop,
  input logic     respValid,
  input aprWord_u respData,
  input logic     respReady
);

  // Credits as seen at the top level, one bit wider than the issuer counter
  logic [COUNT_WIDTH:0] credits;
  int                   failCount = 0;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      credits <= (COUNT_WIDTH + 1)'(QUEUE_DEPTH);
    end else begin
      credits <= credits - (COUNT_WIDTH + 1)'(cmdValid & cmdReady)
                         + (COUNT_WIDTH + 1)'(creditReturn);
    end
  end

  assert property (@(posedge clk) disable iff (!arstN)
    credits <= (COUNT_WIDTH + 1)'(QUEUE_DEPTH))
    else begin
      $error("credit count above queue depth");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (!arstN)
    pushValid |-> $past(credits) != '0)
    else begin
      $error("push issued with no credit left");
      failCount++;
    end

  // Held response must not change under back-pressure
  assert property (@(posedge clk) disable iff (!arstN)
    respValid && !respReady |=> respValid && $stable(respData))
    else begin
      $error("response dropped or changed while stalled");
      failCount++;
    end

  // A popped entry belongs to a command whose credit is still out
  assert property (@(posedge clk) disable iff (!arstN)
    pop |-> headValid && credits != (COUNT_WIDTH + 1)'(QUEUE_DEPTH))
    else begin
      $error("pop without a valid queue head");
      failCount++;
    end

endmodule

`default_nettype wire

// File: testbench/aprTestdata.txt
// Columns, all hex: kind op data expected
// Kinds: 0 end test, 1 write, 2 read, 3 event, 4 irq/piLevel, 5 blocks, 6 stall, 7 drain,
// 8 burst command, 9 credits gone, F end of file
1 0 0540F 00000
1 0 05105 00000
2 2 00000 10F05
4 0 00000 0000D
0 0 00001 00000
1 0 052FF 00000
2 2 00000 00F00
4 0 00000 00000
3 0 000F0 00000
4 0 00000 00000
2 2 00000 00FF0
3 0 00002 00000
4 0 00000 0000D
2 2 00000 10FF2
0 0 00002 00000
1 0 05280 00000
2 2 00000 10F72
4 0 00000 0000D
1 0 05202 00000
2 2 00000 00F70
4 0 00000 00000
0 0 00003 00000
1 1 002E7 00000
2 3 00000 002E6
5 0 00000 00036
1 1 00522 00000
2 3 00000 00566
5 0 00000 00036
0 0 00004 00000
6 0 00000 00000
8 2 00000 00F70
8 3 00000 00566
8 1 0003B 00000
8 3 00000 0003A
8 2 00000 00F70
9 0 00000 00000
7 0 00000 00000
5 0 00000 00053
0 0 00005 00000
F 0 00000 00000
